//--- hw/memArbPkg.sv
// package with sizes, vector types and the arbiter state encoding

package memArbPkg;

  // ####################
  // sizes
  // ####################

  localparam int nMasters   = 4;  // peer command masters.
  localparam int sliceLen   = 4;  // cycles per grant slice.
  localparam int addrW      = 6;  // 64-word RAM.
  localparam int dataW      = 16;
  localparam int queueDepth = 4;  // commands held per master.

  // ####################
  // types
  // ####################

  typedef logic [addrW-1:0]    addr_t;     // RAM word address.
  typedef logic [dataW-1:0]    data_t;     // RAM data word.
  typedef logic [nMasters-1:0] grant_t;    // one-hot with bit i owning the RAM.
  typedef logic [1:0]          slotCnt_t;  // position inside a slice.

  // one state per owner and idle when nobody holds the RAM
  typedef enum logic [2:0] {
    idle = 3'd0,
    own0 = 3'd1,
    own1 = 3'd2,
    own2 = 3'd3,
    own3 = 3'd4
  } arbState_e;

endpackage

//--- hw/sliceArbiter.sv
// time-slice round-robin arbiter with one state per owner and a slice counter

`timescale 1ns/1ps

module sliceArbiter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [memArbPkg::nMasters-1:0] req,
  output memArbPkg::grant_t             gnt
);

  memArbPkg::arbState_e state;
  memArbPkg::arbState_e nextState;
  memArbPkg::slotCnt_t  cnt;
  logic                 sliceEnd;
  logic                 clrCnt;
  logic [$clog2(memArbPkg::nMasters)-1:0] ownerIdx;

  // first requester found when scanning from start, wrapping around;
  // the last position scanned is the one just before start
  function automatic memArbPkg::arbState_e pickOwner(
    input int unsigned                    start,
    input logic [memArbPkg::nMasters-1:0] reqV
  );
    memArbPkg::arbState_e sel;
    int unsigned          idx;
    logic                 found;
    sel   = memArbPkg::idle;
    found = 1'b0;
    for (int off = 0; off < memArbPkg::nMasters; off++) begin
      idx = (start + off) % memArbPkg::nMasters;
      if (!found && reqV[idx]) begin
        sel   = memArbPkg::arbState_e'(3'(idx + 1));
        found = 1'b1;
      end
    end
    return sel;
  endfunction

  // ####################
  // slice counter
  // ####################

  assign ownerIdx = ($clog2(memArbPkg::nMasters))'(state - 3'd1);  // owner number.
  assign sliceEnd = (cnt == memArbPkg::slotCnt_t'(memArbPkg::sliceLen - 1));
  assign clrCnt   = (state == memArbPkg::idle) || sliceEnd;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cnt <= '0;
    end else if (clrCnt) begin
      cnt <= '0;  // new slice starts at zero.
    end else begin
      cnt <= cnt + 2'd1;
    end
  end

  // ####################
  // state machine
  // ####################

  always_comb begin
    nextState = state;
    if (state == memArbPkg::idle) begin
      nextState = pickOwner(0, req);  // scan from master 0.
    end else if (sliceEnd) begin
      // rotate past the current owner, which is scanned last
      nextState = pickOwner((int'(ownerIdx) + 1) % memArbPkg::nMasters, req);
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= memArbPkg::idle;
    end else begin
      state <= nextState;
    end
  end

  // grant decoded from the registered state.
  always_comb begin
    for (int i = 0; i < memArbPkg::nMasters; i++) begin
      gnt[i] = (state == memArbPkg::arbState_e'(3'(i + 1)));
    end
  end

endmodule

//--- hw/cmdQueueMaster.sv
// command master with a circular command queue, request level and granted issue

`timescale 1ns/1ps

module cmdQueueMaster (
  input  logic             clk,
  input  logic             rst,
  input  logic             cmdValid,
  input  logic             cmdWrite,
  input  memArbPkg::addr_t cmdAddr,
  input  memArbPkg::data_t cmdData,
  output logic             cmdFull,
  output logic             req,
  input  logic             gntMine,
  output logic             memEn,
  output logic             memWe,
  output memArbPkg::addr_t memAddr,
  output memArbPkg::data_t memWdata
);

  // queue storage as one field array per command part
  logic             qWrite [memArbPkg::queueDepth];
  memArbPkg::addr_t qAddr  [memArbPkg::queueDepth];
  memArbPkg::data_t qData  [memArbPkg::queueDepth];

  logic [$clog2(memArbPkg::queueDepth)-1:0] wrPtr;
  logic [$clog2(memArbPkg::queueDepth)-1:0] rdPtr;
  logic [$clog2(memArbPkg::queueDepth):0]   count;
  logic                                     push;
  logic                                     pop;

  assign cmdFull = (count == memArbPkg::queueDepth);
  assign req     = (count != '0);  // level while anything is queued.
  assign push    = cmdValid && !cmdFull;  // push on a full queue is dropped.
  assign pop     = gntMine && req;

  // ####################
  // storage
  // ####################

  always_ff @(posedge clk) begin
    if (push) begin
      qWrite[wrPtr] <= cmdWrite;
      qAddr[wrPtr]  <= cmdAddr;
      qData[wrPtr]  <= cmdData;
    end
  end

  // ####################
  // pointers and count
  // ####################

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;  // wraps at queueDepth.
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither.
      endcase
    end
  end

  // head entry goes straight to the RAM port while granted
  assign memEn    = pop;
  assign memWe    = pop && qWrite[rdPtr];
  assign memAddr  = qAddr[rdPtr];
  assign memWdata = qData[rdPtr];

endmodule

//--- hw/sharedRam.sv
// single-port RAM with a grant-steered input mux and read-return routing

`timescale 1ns/1ps

module sharedRam (
  input  logic                           clk,
  input  logic                           rst,
  input  memArbPkg::grant_t              gnt,
  input  logic [memArbPkg::nMasters-1:0] memEn,
  input  logic [memArbPkg::nMasters-1:0] memWe,
  input  memArbPkg::addr_t               memAddr  [memArbPkg::nMasters],
  input  memArbPkg::data_t               memWdata [memArbPkg::nMasters],
  output logic [memArbPkg::nMasters-1:0] rdValid,
  output memArbPkg::data_t               rdData
);

  memArbPkg::data_t mem [2**memArbPkg::addrW];

  logic             selEn;
  logic             selWe;
  memArbPkg::addr_t selAddr;
  memArbPkg::data_t selWdata;

  // ####################
  // input mux
  // ####################

  // and-or select that relies on a one-hot or zero gnt
  always_comb begin
    selEn    = 1'b0;
    selWe    = 1'b0;
    selAddr  = '0;
    selWdata = '0;
    for (int i = 0; i < memArbPkg::nMasters; i++) begin
      selEn    = selEn | (gnt[i] & memEn[i]);
      selWe    = selWe | (gnt[i] & memWe[i]);
      selAddr  = selAddr | (memAddr[i] & {memArbPkg::addrW{gnt[i]}});
      selWdata = selWdata | (memWdata[i] & {memArbPkg::dataW{gnt[i]}});
    end
  end

  // ####################
  // array
  // ####################

  always_ff @(posedge clk) begin
    if (selEn) begin
      if (selWe) begin
        mem[selAddr] <= selWdata;
      end else begin
        rdData <= mem[selAddr];  // valid one cycle after the access.
      end
    end
  end

  // issuing master's grant bit delayed to line up with rdData
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rdValid <= '0;
    end else if (selEn && !selWe) begin
      rdValid <= gnt;
    end else begin
      rdValid <= '0;
    end
  end

endmodule

//--- hw/sharedMemSys.sv
// top level with four command masters, the slice arbiter and the shared RAM

`timescale 1ns/1ps

module sharedMemSys (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [memArbPkg::nMasters-1:0] cmdValid,
  input  logic [memArbPkg::nMasters-1:0] cmdWrite,
  input  memArbPkg::addr_t               cmdAddr [memArbPkg::nMasters],
  input  memArbPkg::data_t               cmdData [memArbPkg::nMasters],
  output logic [memArbPkg::nMasters-1:0] cmdFull,
  output logic [memArbPkg::nMasters-1:0] rdValid,
  output memArbPkg::data_t               rdData,
  output memArbPkg::grant_t              gnt
);

  // ####################
  // master to RAM wiring
  // ####################

  logic [memArbPkg::nMasters-1:0] req;
  logic [memArbPkg::nMasters-1:0] memEn;
  logic [memArbPkg::nMasters-1:0] memWe;
  memArbPkg::addr_t               memAddr  [memArbPkg::nMasters];
  memArbPkg::data_t               memWdata [memArbPkg::nMasters];

  for (genvar i = 0; i < memArbPkg::nMasters; i++) begin : gMaster
    cmdQueueMaster queueMaster (
      .clk      (clk),
      .rst      (rst),
      .cmdValid (cmdValid[i]),
      .cmdWrite (cmdWrite[i]),
      .cmdAddr  (cmdAddr[i]),
      .cmdData  (cmdData[i]),
      .cmdFull  (cmdFull[i]),
      .req      (req[i]),
      .gntMine  (gnt[i]),  // own bit of the shared grant.
      .memEn    (memEn[i]),
      .memWe    (memWe[i]),
      .memAddr  (memAddr[i]),
      .memWdata (memWdata[i])
    );
  end

  // ####################
  // arbiter and RAM
  // ####################

  sliceArbiter arbiter (
    .clk (clk),
    .rst (rst),
    .req (req),
    .gnt (gnt)
  );

  sharedRam ram (
    .clk      (clk),
    .rst      (rst),
    .gnt      (gnt),
    .memEn    (memEn),
    .memWe    (memWe),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .rdValid  (rdValid),
    .rdData   (rdData)
  );

endmodule

//--- bench/sharedMemSys_checker.sv
// concurrent assertions on grant shape, slice length and read-return routing

`timescale 1ns/1ps

module sharedMemSysChecker (
  input logic                           clk,
  input logic                           rst,
  input memArbPkg::grant_t              gnt,
  input logic [memArbPkg::nMasters-1:0] memEn,
  input logic [memArbPkg::nMasters-1:0] memWe,
  input logic [memArbPkg::nMasters-1:0] rdValid
);

  memArbPkg::grant_t lastGnt;
  int                heldLen;  // samples the last gnt value has been held.

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      lastGnt <= '0;
      heldLen <= 0;
    end else begin
      lastGnt <= gnt;
      heldLen <= (gnt == lastGnt) ? heldLen + 1 : 1;
    end
  end

  // at most one owner.
  gntOneHot: assert property (@(posedge clk) disable iff (!rst) $onehot0(gnt))
    else $error("gnt is neither one-hot nor zero: %h", gnt);

  // an owner gives up the RAM only at a slice boundary
  gntFullSlice: assert property (@(posedge clk) disable iff (!rst)
    (lastGnt != '0 && gnt != lastGnt) |-> ((heldLen % memArbPkg::sliceLen) == 0))
    else $error("gnt %h changed after %0d cycles", lastGnt, heldLen);

  rdFromRead: assert property (@(posedge clk) disable iff (!rst)
    (rdValid != '0) |-> (rdValid == $past(gnt & memEn & ~memWe)))
    else $error("rdValid %h without a read access by that master", rdValid);

endmodule

bind sharedRam sharedMemSysChecker ramChecker (
  .clk     (clk),
  .rst     (rst),
  .gnt     (gnt),
  .memEn   (memEn),
  .memWe   (memWe),
  .rdValid (rdValid)
);

//--- bench/sharedMemSysTb.sv
// testbench with a stimulus table, reference model, compare tasks and a timeout

`timescale 1ns/1ps

module sharedMemSysTb;

  typedef struct packed {
    logic [1:0]       master;
    logic             write;
    memArbPkg::addr_t addr;
    memArbPkg::data_t data;
    logic [4:0]       gap;
  } row_t;

  logic                           clk;
  logic                           rst;
  logic [memArbPkg::nMasters-1:0] cmdValid;
  logic [memArbPkg::nMasters-1:0] cmdWrite;
  memArbPkg::addr_t               cmdAddr [memArbPkg::nMasters];
  memArbPkg::data_t               cmdData [memArbPkg::nMasters];
  logic [memArbPkg::nMasters-1:0] cmdFull;
  logic [memArbPkg::nMasters-1:0] rdValid;
  memArbPkg::data_t               rdData;
  memArbPkg::grant_t              gnt;

  row_t tbl [$];

  // ####################
  // reference model
  // ####################

  memArbPkg::data_t               refMem [2**memArbPkg::addrW];
  memArbPkg::data_t               expQ   [memArbPkg::nMasters][$];  // reads in push order.
  bit                             isWrQ  [memArbPkg::nMasters][$];
  int                             mCount [memArbPkg::nMasters];
  int                             mOwner;  // -1 while idle.
  int                             mSlot;
  logic [memArbPkg::nMasters-1:0] mRdExp;
  bit                             sawFull;

  int cycleCnt = 0;
  int cycleLimit;

  sharedMemSys dut_i (
    .clk      (clk),
    .rst      (rst),
    .cmdValid (cmdValid),
    .cmdWrite (cmdWrite),
    .cmdAddr  (cmdAddr),
    .cmdData  (cmdData),
    .cmdFull  (cmdFull),
    .rdValid  (rdValid),
    .rdData   (rdData),
    .gnt      (gnt)
  );

  always #2 clk = ~clk;

  task automatic failNow(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkData(input string name, input memArbPkg::data_t got,
                           input memArbPkg::data_t exp);
    if (got !== exp) begin
      failNow($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkGrant(input string name, input memArbPkg::grant_t got,
                            input memArbPkg::grant_t exp);
    if (got !== exp) begin
      failNow($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkFlags(input string name, input logic [memArbPkg::nMasters-1:0] got,
                            input logic [memArbPkg::nMasters-1:0] exp);
    if (got !== exp) begin
      failNow($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  // nearest requester at or after from with wrap-around.
  function automatic int rotatePick(input int from, input logic [memArbPkg::nMasters-1:0] reqV);
    int pick;
    pick = -1;
    for (int k = memArbPkg::nMasters - 1; k >= 0; k--) begin
      if (reqV[(from + k) % memArbPkg::nMasters]) begin
        pick = (from + k) % memArbPkg::nMasters;
      end
    end
    return pick;
  endfunction

  function automatic memArbPkg::grant_t modelGrant();
    memArbPkg::grant_t g;
    g = '0;
    if (mOwner >= 0) begin
      g[mOwner] = 1'b1;
    end
    return g;
  endfunction

  function automatic logic [memArbPkg::nMasters-1:0] modelFull();
    logic [memArbPkg::nMasters-1:0] f;
    for (int m = 0; m < memArbPkg::nMasters; m++) begin
      f[m] = (mCount[m] == memArbPkg::queueDepth);
    end
    return f;
  endfunction

  function automatic bit modelDrained();
    bit quiet;
    quiet = (mOwner < 0) && (mRdExp == '0);
    for (int m = 0; m < memArbPkg::nMasters; m++) begin
      quiet = quiet && (mCount[m] == 0) && (expQ[m].size() == 0);
    end
    return quiet;
  endfunction

  // moves the model across the next rising edge
  task automatic advanceModel();
    logic [memArbPkg::nMasters-1:0] reqV;
    logic [memArbPkg::nMasters-1:0] nextRd;
    bit                             wasWrite;
    for (int m = 0; m < memArbPkg::nMasters; m++) begin
      reqV[m] = (mCount[m] != 0);
    end
    nextRd = '0;
    if (mOwner >= 0 && reqV[mOwner]) begin
      wasWrite       = isWrQ[mOwner].pop_front();
      mCount[mOwner] = mCount[mOwner] - 1;
      if (!wasWrite) begin
        nextRd[mOwner] = 1'b1;  // data returns one cycle later.
      end
    end
    for (int m = 0; m < memArbPkg::nMasters; m++) begin
      if (cmdValid[m]) begin
        mCount[m] = mCount[m] + 1;
        isWrQ[m].push_back(cmdWrite[m]);
        if (cmdWrite[m]) begin
          refMem[cmdAddr[m]] = cmdData[m];
        end else begin
          expQ[m].push_back(refMem[cmdAddr[m]]);
        end
      end
    end
    mRdExp = nextRd;
    if (mOwner < 0) begin
      mOwner = rotatePick(0, reqV);
      mSlot  = 0;
    end else if (mSlot == memArbPkg::sliceLen - 1) begin
      mOwner = rotatePick((mOwner + 1) % memArbPkg::nMasters, reqV);  // owner scanned last.
      mSlot  = 0;
    end else begin
      mSlot = mSlot + 1;
    end
  endtask

  task automatic addRow(input int m, input bit wr, input int a, input int d, input int gap);
    row_t row;
    row.master = 2'(m);
    row.write  = wr;
    row.addr   = memArbPkg::addr_t'(a);
    row.data   = memArbPkg::data_t'(d);
    row.gap    = 5'(gap);
    tbl.push_back(row);
  endtask

  // each master keeps to its own 16-word range
  task automatic buildTable();
    addRow(0, 1, 'h00, 'hA000, 1);
    addRow(1, 1, 'h10, 'hB010, 0);
    addRow(2, 1, 'h22, 'hC022, 0);
    addRow(3, 1, 'h35, 'hD035, 2);
    addRow(0, 0, 'h00, 'h0000, 0);
    addRow(1, 0, 'h10, 'h0000, 0);
    addRow(2, 0, 'h22, 'h0000, 0);
    addRow(3, 0, 'h35, 'h0000, 3);
    addRow(1, 1, 'h10, 'hB110, 0);
    addRow(1, 0, 'h10, 'h0000, 12);
    // back-to-back pushes where master 0 fills while master 3 holds its slice
    addRow(1, 1, 'h11, 'h1111, 0);
    addRow(1, 1, 'h12, 'h1112, 0);
    addRow(1, 0, 'h11, 'h0000, 0);
    addRow(2, 1, 'h23, 'h2223, 0);
    addRow(2, 0, 'h23, 'h0000, 0);
    addRow(2, 0, 'h22, 'h0000, 0);
    addRow(3, 1, 'h36, 'h3336, 0);
    addRow(3, 0, 'h36, 'h0000, 0);
    addRow(3, 0, 'h35, 'h0000, 0);
    addRow(0, 1, 'h02, 'h0002, 0);
    addRow(0, 0, 'h02, 'h0000, 0);
    addRow(0, 1, 'h03, 'h0003, 0);
    addRow(0, 0, 'h00, 'h0000, 8);
    addRow(0, 0, 'h03, 'h0000, 1);
    addRow(1, 0, 'h12, 'h0000, 0);
  endtask

  task automatic pushRow(input row_t row);
    int                             m;
    logic [memArbPkg::nMasters-1:0] sel;
    m      = int'(row.master);
    sel    = '0;
    sel[m] = 1'b1;
    while (mCount[m] >= memArbPkg::queueDepth) begin
      cmdValid <= '0;  // hold off until a pop frees a slot.
      @(posedge clk);
    end
    cmdValid    <= sel;
    cmdWrite[m] <= row.write;
    cmdAddr[m]  <= row.addr;
    cmdData[m]  <= row.data;
  endtask

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleLimit > 0 && cycleCnt >= cycleLimit) begin
      failNow("timeout: the test did not finish within the cycle limit");
    end
  end

  initial begin : monitor
    memArbPkg::data_t expVal;
    mOwner  = -1;
    mSlot   = 0;
    mRdExp  = '0;
    sawFull = 1'b0;
    for (int m = 0; m < memArbPkg::nMasters; m++) begin
      mCount[m] = 0;
    end
    wait (rst === 1'b1);
    forever begin
      @(negedge clk);
      checkGrant("gnt", gnt, modelGrant());
      checkFlags("cmdFull", cmdFull, modelFull());
      checkFlags("rdValid", rdValid, mRdExp);
      for (int m = 0; m < memArbPkg::nMasters; m++) begin
        if (mRdExp[m]) begin
          expVal = expQ[m].pop_front();
          checkData("rdData", rdData, expVal);
        end
      end
      if (cmdFull != '0) begin
        sawFull = 1'b1;
      end
      advanceModel();
    end
  end

  initial begin : stimulus
    int gap;
    void'($urandom(32'h6a8a184b));
    clk      = 1'b0;
    rst      <= 1'b0;
    cmdValid <= '0;
    cmdWrite <= '0;
    for (int m = 0; m < memArbPkg::nMasters; m++) begin
      cmdAddr[m] <= '0;
      cmdData[m] <= '0;
    end
    buildTable();
    cycleLimit = tbl.size() * memArbPkg::nMasters * memArbPkg::sliceLen + 200;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    for (int r = 0; r < tbl.size(); r++) begin
      @(posedge clk);
      pushRow(tbl[r]);
      gap = int'(tbl[r].gap);
      if (gap != 0) begin
        gap = gap + int'($urandom % 3);  // random extra idle cycles.
      end
      repeat (gap) begin
        @(posedge clk);
        cmdValid <= '0;
      end
    end
    @(posedge clk);
    cmdValid <= '0;
    while (!modelDrained()) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (!sawFull) begin
      failNow("cmdFull never rose during the back-to-back pushes");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

//--- flist.f
hw/memArbPkg.sv
hw/sliceArbiter.sv
hw/cmdQueueMaster.sv
hw/sharedRam.sv
hw/sharedMemSys.sv
bench/sharedMemSys_checker.sv
bench/sharedMemSysTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the shared-memory testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module sharedMemSysTb \
  -f flist.f \
  --Mdir obj_dir

./obj_dir/VsharedMemSysTb | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  exit 0
fi

echo "simulation failed, see sim.log" >&2
exit 1
